// File: Bender.yml
package:
  name: regex_top

sources:
  - files:
      - hdl/regex_pkg.sv
      - hdl/pkt_mem_bank.sv
      - hdl/regex_wb_regs.sv
      - hdl/regex_fetch.sv
      - hdl/regex_byte_sel.sv
      - hdl/regex_dfa.sv
      - hdl/regex_top.sv
  - target: simulation
    files:
      - sim/regex_sva.sv
      - sim/regex_tb.sv

// File: hdl/pkt_mem_bank.sv
module pkt_mem_bank (
    input  logic                             clk,
    input  regex_pkg::mem_wr_t               wr,
    input  logic                             rd_en,
    input  logic [regex_pkg::LINE_IDX_W-1:0] rd_line,
    output logic [regex_pkg::LINE_W-1:0]     rd_data
);

    logic [regex_pkg::LINE_W-1:0] mem [regex_pkg::BANK_LINES];

    // write port from the bus side
    always_ff @(posedge clk) begin
        if (wr.we) begin
            for (int i = 0; i < regex_pkg::LINE_BYTES; i++) begin
                if (wr.sel[i]) begin
                    mem[wr.line][i*8 +: 8] <= wr.data[i*8 +: 8];
                end
            end
        end
    end

    // read port for the scan pipeline, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_line];
        end
    end

endmodule

// File: hdl/regex_byte_sel.sv
module regex_byte_sel (
    input  logic                         clk,
    input  logic                         rst,
    input  regex_pkg::fetch_req_t        req,
    input  logic [regex_pkg::LINE_W-1:0] rd_data0,
    input  logic [regex_pkg::LINE_W-1:0] rd_data1,
    input  logic                         stop,
    output regex_pkg::byte_beat_t        beat
);

    regex_pkg::fetch_req_t         req_q;
    logic [regex_pkg::LINE_W-1:0]  line;
    logic [7:0]                    data;

    // request waits here while the bank reads its line
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else if (stop) begin
            req_q <= '0;
        end else begin
            req_q <= req;
        end
    end

    assign line = req_q.addr.part.bank ? rd_data1 : rd_data0;
    assign data = line[req_q.addr.part.offset*8 +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else if (stop) begin
            beat <= '0;                                  // drop whatever is still in flight
        end else begin
            beat <= '{valid: req_q.valid, data: data, last: req_q.last};
        end
    end

endmodule

// File: hdl/regex_dfa.sv
module regex_dfa (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  stop,
    input  logic                  zero_done,
    input  regex_pkg::byte_beat_t beat,
    output logic                  done,
    output logic                  match
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_A,                                            // seen an a
        ST_B,                                            // seen a then at least one b
        ST_C                                             // pattern complete
    } state_t;

    state_t state_q;
    state_t state_d;

    ////////////////////
    // next state

    always_comb begin
        state_d = ST_IDLE;
        if (beat.data == regex_pkg::CH_A) begin
            state_d = ST_A;                              // an a always restarts the pattern
        end else if (beat.data == regex_pkg::CH_B) begin
            if (state_q == ST_A || state_q == ST_B) begin
                state_d = ST_B;
            end
        end else if (beat.data == regex_pkg::CH_C) begin
            if (state_q == ST_B) begin
                state_d = ST_C;
            end
        end
    end

    ////////////////////
    // state and status

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            done    <= 1'b0;
            match   <= 1'b0;
        end else if (start) begin
            state_q <= ST_IDLE;
            done    <= 1'b0;
            match   <= 1'b0;
        end else if (stop) begin
            state_q <= ST_IDLE;
            done    <= 1'b1;                             // match keeps its value
        end else begin
            if (beat.valid) begin
                state_q <= state_d;
                if (state_d == ST_C) begin
                    match <= 1'b1;
                end
                if (beat.last) begin
                    done <= 1'b1;
                end
            end
            if (zero_done) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/regex_fetch.sv
module regex_fetch (
    input  logic                             clk,
    input  logic                             rst,
    input  regex_pkg::scan_cmd_t             cmd,
    output regex_pkg::fetch_req_t            req,
    output logic                             rd_en0,
    output logic                             rd_en1,
    output logic [regex_pkg::LINE_IDX_W-1:0] rd_line,
    output logic                             busy,
    output logic                             zero_done
);

    regex_pkg::pkt_addr_u          addr_q;
    logic [regex_pkg::LEN_W-1:0]   remain_q;
    logic                          accept;
    logic                          issue;
    logic                          is_last;

    ////////////////////
    // command accept

    assign accept  = cmd.start & ~busy & ~cmd.stop;
    assign issue   = busy & ~cmd.stop;                   // a stop kills the request of this cycle
    assign is_last = remain_q == regex_pkg::LEN_W'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            zero_done <= 1'b0;
        end else begin
            zero_done <= 1'b0;
            if (cmd.stop) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy      <= cmd.len != '0;
                zero_done <= cmd.len == '0;              // nothing to fetch, report done directly
            end else if (busy && is_last) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////
    // address and length walk

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= cmd.addr;
            remain_q <= cmd.len;
        end else if (busy) begin
            addr_q.flat <= addr_q.flat + 1'b1;           // wraps at the end of packet memory
            remain_q    <= remain_q - 1'b1;
        end
    end

    always_comb begin
        req.valid = issue;
        req.addr  = addr_q;
        req.last  = is_last;
    end

    // only the bank that owns the line sees a read
    assign rd_en0  = issue & ~addr_q.part.bank;
    assign rd_en1  = issue & addr_q.part.bank;
    assign rd_line = addr_q.part.line;

endmodule

// File: hdl/regex_pkg.sv
package regex_pkg;

    ////////////////////
    // sizes

    localparam int LINE_BYTES = 4;                       // one line is one bus word
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int BANK_LINES = 64;
    localparam int LINE_IDX_W = $clog2(BANK_LINES);
    localparam int OFF_W      = $clog2(LINE_BYTES);
    localparam int PKT_ADDR_W = 9;                       // 512 bytes over both banks
    localparam int LEN_W      = 16;
    localparam int WB_ADR_W   = 12;

    ////////////////////
    // register map

    localparam logic [WB_ADR_W-1:0] REG_BASE     = 12'h200;   // below this is packet memory
    localparam logic [WB_ADR_W-1:0] REG_CMD_ADDR = 12'h000;
    localparam logic [WB_ADR_W-1:0] REG_CMD_LEN  = 12'h004;   // write starts a scan
    localparam logic [WB_ADR_W-1:0] REG_CTRL     = 12'h008;
    localparam logic [WB_ADR_W-1:0] REG_STATUS   = 12'h00C;

    localparam int CTRL_STOP    = 0;
    localparam int STAT_READY   = 0;
    localparam int STAT_DONE    = 1;
    localparam int STAT_MATCH   = 2;

    // pattern characters
    localparam logic [7:0] CH_A = 8'h61;
    localparam logic [7:0] CH_B = 8'h62;
    localparam logic [7:0] CH_C = 8'h63;

    ////////////////////
    // types

    typedef struct packed {
        logic [LINE_IDX_W-1:0] line;
        logic                  bank;                     // alternate lines sit in alternate banks
        logic [OFF_W-1:0]      offset;
    } pkt_fields_t;

    typedef union packed {
        logic [PKT_ADDR_W-1:0] flat;                     // stepped during a scan
        pkt_fields_t           part;                     // steers the bank reads
    } pkt_addr_u;

    typedef struct packed {
        logic      valid;
        pkt_addr_u addr;
        logic      last;
    } fetch_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    typedef struct packed {
        logic             start;
        logic             stop;
        pkt_addr_u        addr;
        logic [LEN_W-1:0] len;
    } scan_cmd_t;

    typedef struct packed {
        logic                  we;
        logic [LINE_IDX_W-1:0] line;
        logic [LINE_BYTES-1:0] sel;
        logic [LINE_W-1:0]     data;
    } mem_wr_t;

endpackage

// File: hdl/regex_top.sv
module regex_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [regex_pkg::WB_ADR_W-1:0]   wb_adr,
    input  logic [regex_pkg::LINE_BYTES-1:0] wb_sel,
    input  logic [regex_pkg::LINE_W-1:0]     wb_dat_w,
    output logic [regex_pkg::LINE_W-1:0]     wb_dat_r,
    output logic                             wb_ack
);

    regex_pkg::mem_wr_t               mem_wr0;
    regex_pkg::mem_wr_t               mem_wr1;
    regex_pkg::scan_cmd_t             cmd;
    regex_pkg::fetch_req_t            req;
    regex_pkg::byte_beat_t            beat;
    logic                             rd_en0;
    logic                             rd_en1;
    logic [regex_pkg::LINE_IDX_W-1:0] rd_line;
    logic [regex_pkg::LINE_W-1:0]     rd_data0;
    logic [regex_pkg::LINE_W-1:0]     rd_data1;
    logic                             busy;
    logic                             zero_done;
    logic                             done;
    logic                             match;

    regex_wb_regs u_regs (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .mem_wr0(mem_wr0), .mem_wr1(mem_wr1), .cmd(cmd),
        .busy(busy), .done(done), .match(match)
    );

    pkt_mem_bank bank0 (
        .clk(clk), .wr(mem_wr0), .rd_en(rd_en0), .rd_line(rd_line), .rd_data(rd_data0)
    );

    pkt_mem_bank bank1 (
        .clk(clk), .wr(mem_wr1), .rd_en(rd_en1), .rd_line(rd_line), .rd_data(rd_data1)
    );

    regex_fetch u_fetch (
        .clk(clk), .rst(rst), .cmd(cmd), .req(req),
        .rd_en0(rd_en0), .rd_en1(rd_en1), .rd_line(rd_line),
        .busy(busy), .zero_done(zero_done)
    );

    regex_byte_sel u_byte_sel (
        .clk(clk), .rst(rst), .req(req), .rd_data0(rd_data0), .rd_data1(rd_data1),
        .stop(cmd.stop), .beat(beat)
    );

    regex_dfa u_dfa (
        .clk(clk), .rst(rst), .start(cmd.start), .stop(cmd.stop),
        .zero_done(zero_done), .beat(beat), .done(done), .match(match)
    );

endmodule

// File: hdl/regex_wb_regs.sv
module regex_wb_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [regex_pkg::WB_ADR_W-1:0]   wb_adr,
    input  logic [regex_pkg::LINE_BYTES-1:0] wb_sel,
    input  logic [regex_pkg::LINE_W-1:0]     wb_dat_w,
    output logic [regex_pkg::LINE_W-1:0]     wb_dat_r,
    output logic                             wb_ack,
    output regex_pkg::mem_wr_t               mem_wr0,
    output regex_pkg::mem_wr_t               mem_wr1,
    output regex_pkg::scan_cmd_t             cmd,
    input  logic                             busy,
    input  logic                             done,
    input  logic                             match
);

    logic                               xfer;
    logic                               is_mem;
    logic [regex_pkg::WB_ADR_W-1:0]     word_adr;
    logic                               hit_addr;
    logic                               hit_len;
    logic                               hit_ctrl;
    logic                               hit_status;
    logic                               start_ok;
    regex_pkg::pkt_addr_u               wr_addr;
    logic [regex_pkg::LINE_W-1:0]       rd_word;

    logic                               we0_q;
    logic                               we1_q;
    logic [regex_pkg::LINE_IDX_W-1:0]   line_q;
    logic [regex_pkg::LINE_BYTES-1:0]   sel_q;
    logic [regex_pkg::LINE_W-1:0]       data_q;
    logic                               start_q;
    logic                               stop_q;
    regex_pkg::pkt_addr_u               addr_q;
    logic [regex_pkg::LEN_W-1:0]        len_q;

    ////////////////////
    // decode

    assign xfer     = wb_cyc & wb_stb & ~wb_ack;         // ack gap keeps one answer per request
    assign is_mem   = wb_adr < regex_pkg::REG_BASE;
    assign word_adr = {wb_adr[regex_pkg::WB_ADR_W-1:2], 2'b00};

    assign hit_addr   = word_adr == regex_pkg::REG_BASE + regex_pkg::REG_CMD_ADDR;
    assign hit_len    = word_adr == regex_pkg::REG_BASE + regex_pkg::REG_CMD_LEN;
    assign hit_ctrl   = word_adr == regex_pkg::REG_BASE + regex_pkg::REG_CTRL;
    assign hit_status = word_adr == regex_pkg::REG_BASE + regex_pkg::REG_STATUS;

    assign start_ok = xfer & wb_we & hit_len & ~busy;    // a start while busy is acked and dropped
    assign wr_addr.flat = wb_adr[regex_pkg::PKT_ADDR_W-1:0];

    always_comb begin
        rd_word = '0;
        if (hit_status) begin
            rd_word[regex_pkg::STAT_READY] = ~busy;
            rd_word[regex_pkg::STAT_DONE]  = done;
            rd_word[regex_pkg::STAT_MATCH] = match;
        end else if (hit_addr) begin
            rd_word[regex_pkg::PKT_ADDR_W-1:0] = addr_q.flat;
        end else if (hit_len) begin
            rd_word[regex_pkg::LEN_W-1:0] = len_q;
        end
    end

    ////////////////////
    // registers

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack  <= 1'b0;
            we0_q   <= 1'b0;
            we1_q   <= 1'b0;
            start_q <= 1'b0;
            stop_q  <= 1'b0;
        end else begin
            wb_ack  <= xfer;
            we0_q   <= xfer & wb_we & is_mem & ~wr_addr.part.bank;
            we1_q   <= xfer & wb_we & is_mem & wr_addr.part.bank;
            start_q <= start_ok;                         // lines up with ack
            stop_q  <= xfer & wb_we & hit_ctrl & wb_dat_w[regex_pkg::CTRL_STOP];
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            line_q   <= wr_addr.part.line;
            sel_q    <= wb_sel;
            data_q   <= wb_dat_w;
            wb_dat_r <= rd_word;
        end
        if (xfer && wb_we && hit_addr) begin
            addr_q.flat <= wb_dat_w[regex_pkg::PKT_ADDR_W-1:0];
        end
        if (start_ok) begin
            len_q <= wb_dat_w[regex_pkg::LEN_W-1:0];
        end
    end

    // both banks share the write payload, only the enable is routed
    assign mem_wr0 = '{we: we0_q, line: line_q, sel: sel_q, data: data_q};
    assign mem_wr1 = '{we: we1_q, line: line_q, sel: sel_q, data: data_q};

    assign cmd = '{start: start_q, stop: stop_q, addr: addr_q, len: len_q};

endmodule

// File: regex_top.f
hdl/regex_pkg.sv
hdl/pkt_mem_bank.sv
hdl/regex_wb_regs.sv
hdl/regex_fetch.sv
hdl/regex_byte_sel.sv
hdl/regex_dfa.sv
hdl/regex_top.sv
sim/regex_sva.sv
sim/regex_tb.sv

// File: sim/regex_sva.sv
module regex_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_ack,
    input regex_pkg::byte_beat_t beat,
    input logic                  busy
);
    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////
    // bus rules

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack was high for two cycles in a row");

    // ack answers the request seen one cycle earlier
    ack_for_xfer: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack came without a bus transfer");

    ////////////////////
    // pipeline rules

    // a beat reaches the matcher two cycles after its request left a busy engine
    beat_when_busy: assert property (@(posedge clk) disable iff (rst)
        beat.valid |-> $past(busy, 2))
        else $error("byte beat delivered without a request from a busy engine");

endmodule

bind regex_top regex_sva sva0 (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .beat(beat), .busy(busy)
);

// File: sim/regex_tb.sv
module regex_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 500;

    localparam logic [11:0] ADR_CMD_ADDR = regex_pkg::REG_BASE + regex_pkg::REG_CMD_ADDR;
    localparam logic [11:0] ADR_CMD_LEN  = regex_pkg::REG_BASE + regex_pkg::REG_CMD_LEN;
    localparam logic [11:0] ADR_CTRL     = regex_pkg::REG_BASE + regex_pkg::REG_CTRL;
    localparam logic [11:0] ADR_STATUS   = regex_pkg::REG_BASE + regex_pkg::REG_STATUS;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [11:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    logic [7:0]  pkt [512];                              // host copy of packet memory
    int          errors;
    int          timeouts;
    bit          aborted;
    integer      seed;

    regex_top dut0 (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    always #50 clk = ~clk;

    ////////////////////
    // bus access

    task automatic bus_transfer(input logic we, input logic [11:0] adr, input logic [31:0] dat,
                                output logic [31:0] rdat);
        int n;
        rdat = '0;
        n = 0;
        if (aborted) return;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_sel   = 4'hF;
        wb_dat_w = dat;
        @(negedge clk);
        while (!wb_ack && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (wb_ack) begin
            rdat = wb_dat_r;
        end else begin
            $display("timeout at %0t: the slave never acked address %h", $time, adr);
            timeouts++;
            aborted = 1'b1;
        end
        wb_cyc = 1'b0;                                   // master holds until it sees ack
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [11:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_transfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [11:0] adr, output logic [31:0] dat);
        bus_transfer(1'b0, adr, 32'h0, dat);
    endtask

    task automatic wait_done(output logic [31:0] status);
        int n;
        n = 0;
        wb_read(ADR_STATUS, status);
        while (!aborted && !status[regex_pkg::STAT_DONE] && n < POLL_LIMIT) begin
            wb_read(ADR_STATUS, status);
            n++;
        end
        if (!aborted && !status[regex_pkg::STAT_DONE]) begin
            $display("timeout at %0t: the scan never reported done", $time);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    ////////////////////
    // checks and model

    function automatic logic [2:0] status_bits(input logic ready, input logic done,
                                               input logic match);
        logic [2:0] s;
        s = '0;
        s[regex_pkg::STAT_READY] = ready;
        s[regex_pkg::STAT_DONE]  = done;
        s[regex_pkg::STAT_MATCH] = match;
        return s;
    endfunction

    task automatic check_status(input logic [regex_pkg::STAT_MATCH:0] got,
                                input logic [regex_pkg::STAT_MATCH:0] exp, input string what);
        if (aborted) return;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s status %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (aborted) return;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // scans for an a, then a run of b, then a c, all inside the window
    function automatic logic pattern_in(input int first, input int len);
        int i;
        int j;
        for (i = first; i < first + len; i++) begin
            if (pkt[i] == "a") begin
                j = i + 1;
                while (j < first + len && pkt[j] == "b") begin
                    j++;
                end
                if (j > i + 1 && j < first + len && pkt[j] == "c") begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    task automatic write_range(input int first, input int len);
        int w;
        for (w = first & ~3; w < first + len; w += 4) begin
            wb_write(12'(w), {pkt[w+3], pkt[w+2], pkt[w+1], pkt[w]});
        end
    endtask

    task automatic run_scan(input int first, input int len, input logic exp_match,
                            input string what);
        logic [31:0] st;
        wb_write(ADR_CMD_ADDR, 32'(first));
        wb_write(ADR_CMD_LEN, 32'(len));
        wait_done(st);
        check_status(st[2:0], status_bits(1'b1, 1'b1, exp_match), what);
    endtask

    ////////////////////
    // directed tests

    task automatic reset_defaults();
        logic [31:0] word;
        wb_read(ADR_STATUS, word);
        check_status(word[2:0], status_bits(1'b1, 1'b0, 1'b0), "after reset");
        wb_read(12'h044, word);
        check_word(word, 32'h0, "packet memory");
        write_range(0, 512);                             // no scan ever reads unwritten lines
    endtask

    task automatic fixed_string_scans();
        string s;
        s = "xxabbbcx";
        for (int i = 0; i < s.len(); i++) begin
            pkt['h40 + i] = s[i];
        end
        write_range('h40, s.len());
        run_scan('h40, 8, pattern_in('h40, 8), "full string");
        run_scan('h43, 5, pattern_in('h43, 5), "string after the a");
    endtask

    task automatic random_packet_scans();
        string letters;
        int    first;
        int    len;
        letters = "abcx";
        repeat (20) begin
            first = 'h100 + ($random(seed) & 3);
            len   = 1 + ($random(seed) & 63);
            for (int i = 0; i < len; i++) begin
                pkt[first + i] = letters[$random(seed) & 3];
            end
            write_range(first, len);
            run_scan(first, len, pattern_in(first, len), "random packet");
        end
    endtask

    task automatic zero_length_scan();
        run_scan('h40, 0, 1'b0, "zero length");
    endtask

    task automatic stopped_scan();
        logic [31:0] st;
        for (int i = 0; i < 297; i++) begin
            pkt[i] = "x";
        end
        pkt[297] = "a";
        pkt[298] = "b";
        pkt[299] = "c";
        write_range(0, 300);
        wb_write(ADR_CMD_ADDR, 32'h0);
        wb_write(ADR_CMD_LEN, 32'd300);
        wb_write(ADR_CTRL, 32'h1);
        wait_done(st);
        check_status(st[2:0], status_bits(1'b1, 1'b1, 1'b0), "stopped scan");
    endtask

    task automatic busy_start_ignored();
        logic [31:0] st;
        logic [31:0] word;
        wb_write(ADR_CMD_ADDR, 32'h0);
        wb_write(ADR_CMD_LEN, 32'd300);
        wb_write(ADR_CMD_ADDR, 32'h10);                  // second command points at plain bytes
        wb_write(ADR_CMD_LEN, 32'd4);
        wb_read(ADR_CMD_LEN, word);
        check_word(word, 32'd300, "length while busy");
        wait_done(st);
        check_status(st[2:0], status_bits(1'b1, 1'b1, pattern_in(0, 300)), "first command");
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_sel   = '0;
        wb_dat_w = '0;
        errors   = 0;
        timeouts = 0;
        aborted  = 1'b0;
        seed     = 15;
        // fill bytes stay out of the pattern alphabet
        for (int i = 0; i < 512; i++) begin
            pkt[i] = 8'h40 | 8'((i ^ (i >> 3) ^ (i >> 6)) & 'h0f);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_defaults();
        fixed_string_scans();
        random_packet_scans();
        zero_length_scan();
        stopped_scan();
        busy_start_ignored();

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
